/* test/aud_stimulus.txt */
// op test arg value...  op 1 write data to address arg, op 2 read address arg and expect value
// op 3 capture arg frames, values are left:right, op 4 wait arg LRCK periods, op 0 ends
// registers after reset, control readback
2 1 1 00000020
1 1 0 0000001E
2 1 0 0000001E
2 1 2 00000000
1 1 0 00000000
// playback at volume 0
1 2 2 12345678  1 2 2 80017FFF
1 2 2 A5A55A5A  1 2 2 FFFF0001
2 2 1 00000004
4 2 1
1 2 0 00000001
3 2 4 12345678 80017FFF A5A55A5A FFFF0001
1 2 0 00000000
2 2 1 00000020
// volume shift 3, rounding toward negative infinity
1 3 2 80007FFF  1 3 2 FFF90039  1 3 2 1234EDCB
4 3 1
1 3 0 0000000D
3 3 3 F0000FFF FFFF0007 0246FDB9
1 3 0 00000000
2 3 1 00000020
// mute plays zeros while the FIFO drains one frame per LRCK period
1 4 2 7FFF8000  1 4 2 11112222
1 4 2 33334444  1 4 2 55556666
4 4 1
1 4 0 00000003
3 4 1 00000000
2 4 1 00000003
3 4 1 00000000
2 4 1 00000002
4 4 1
2 4 1 00000001
4 4 1
2 4 1 00000020
1 4 0 00000000
// underrun plays silence and sets the sticky flag
1 5 2 4000C000
4 5 1
1 5 0 00000001
3 5 2 4000C000 00000000
1 5 0 00000000
2 5 1 00000060
1 5 1 00000040
2 5 1 00000020
// nine writes into an eight frame FIFO, the ninth is dropped
1 6 2 10000001  1 6 2 20000002  1 6 2 30000003
1 6 2 40000004  1 6 2 50000005  1 6 2 60000006
1 6 2 70000007  1 6 2 80000008  1 6 2 90000009
2 6 1 00000018
4 6 1
1 6 0 00000001
3 6 9 10000001 20000002 30000003 40000004 50000005 60000006 70000007 80000008 00000000
1 6 0 00000000
2 6 1 00000060
0

/* files.f */
rtl/aud_pkg.sv
rtl/aud_frame_if.sv
rtl/aud_frame_fifo.sv
rtl/aud_wb_regs.sv
rtl/aud_dsp.sv
rtl/aud_player.sv
rtl/aud_out_top.sv
test/tb_aud_out.sv

/* Makefile */
# Verilator build and run of the audio playback testbench

TOP := tb_aud_out

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

/* test/tb_aud_out.sv */
`default_nettype none

module tb_aud_out;

    localparam int HALF_PERIOD  = 50;
    localparam int DRIVE_DLY    = 10;    // after the rising edge
    localparam int LRCK_HALF    = 32;    // bclk cycles per LRCK half
    localparam int WORD_BITS    = 16;
    localparam int ACK_TIMEOUT  = 16;
    localparam int LRCK_TIMEOUT = 3 * LRCK_HALF;
    localparam int STIM_AW      = 8;

    localparam logic [31:0] OP_END     = 32'd0;
    localparam logic [31:0] OP_WRITE   = 32'd1;
    localparam logic [31:0] OP_READ    = 32'd2;
    localparam logic [31:0] OP_CAPTURE = 32'd3;
    localparam logic [31:0] OP_WAIT    = 32'd4;

    logic        bclk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic        lrck;
    logic        dacdat;

    logic [31:0] stim [2**STIM_AW];
    int          lrck_cnt;
    int          checks;
    int          mismatches;
    int          run_errors;    // timeouts and bad commands

    aud_out_top aud_out_top_inst (
        .i_bclk       (bclk),
        .i_rst_n      (rst_n),
        .i_wb_cyc     (wb_cyc),
        .i_wb_stb     (wb_stb),
        .i_wb_we      (wb_we),
        .i_wb_adr     (wb_adr),
        .i_wb_dat     (wb_wdat),
        .o_wb_dat     (wb_rdat),
        .o_wb_ack     (wb_ack),
        .i_daclrck    (lrck),
        .o_aud_dacdat (dacdat)
    );

    initial begin
        bclk = 1'b0;
        forever #HALF_PERIOD bclk = ~bclk;
    end

    // codec side LRCK of 32 bclk low then 32 high
    initial begin
        lrck     = 1'b1;
        lrck_cnt = 0;
        forever begin
            @(posedge bclk);
            #DRIVE_DLY;
            if (lrck_cnt == LRCK_HALF - 1) begin
                lrck     = ~lrck;
                lrck_cnt = 0;
            end else begin
                lrck_cnt = lrck_cnt + 1;
            end
        end
    end

    function automatic logic [31:0] stim_at(input int idx);
        return stim[idx[STIM_AW-1:0]];
    endfunction

    function automatic string test_name(input logic [31:0] t);
        string s;
        case (t)
            32'd1: s = "registers";
            32'd2: s = "playback";
            32'd3: s = "volume";
            32'd4: s = "mute";
            32'd5: s = "underrun";
            32'd6: s = "full_fifo";
            default: s = "unnamed";
        endcase
        return s;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %08h, actual %08h", what, exp, act);
            mismatches++;
        end
    endtask

    task automatic bus_cycle(input string name, input logic we, input logic [1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        @(posedge bclk);
        #DRIVE_DLY;
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_adr  = adr;
        wb_wdat = wdat;
        n = 0;
        while (!wb_ack && n < ACK_TIMEOUT) begin
            @(negedge bclk);
            n++;
        end
        rdat = wb_rdat;    // registered and valid with ack
        if (!wb_ack) begin
            $display("ERROR: no Wishbone ack within %0d cycles at address %0d", ACK_TIMEOUT, adr);
            run_errors++;
        end else begin
            // ack rises at the first edge after the request, seen at the second negedge
            check($sformatf("%s ack delay at address %0d", name, adr), 32'd2, 32'(n));
        end
        @(posedge bclk);
        #DRIVE_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check($sformatf("%s ack width at address %0d", name, adr), 32'd0, {31'h0, wb_ack});
    endtask

    // returns at the negedge where LRCK first shows the new level
    task automatic wait_lrck_edge(input logic level);
        logic prev;
        logic found;
        int   n;
        found = 1'b0;
        @(negedge bclk);
        prev = lrck;
        for (n = 0; n < LRCK_TIMEOUT && !found; n++) begin
            @(negedge bclk);
            found = (prev != level) && (lrck == level);
            prev  = lrck;
        end
        if (!found) begin
            $display("ERROR: LRCK did not go %s within %0d cycles", level ? "high" : "low",
                     LRCK_TIMEOUT);
            run_errors++;
        end
    endtask

    task automatic shift_in_word(output logic [15:0] w);
        int i;
        w = '0;
        for (i = 0; i < WORD_BITS; i++) begin
            @(negedge bclk);
            w = {w[14:0], dacdat};    // msb first
        end
    endtask

    task automatic capture_frame(output logic [31:0] frame);
        logic [15:0] left;
        logic [15:0] right;
        left  = '0;
        right = '0;
        wait_lrck_edge(1'b0);
        if (run_errors == 0) begin
            shift_in_word(left);
            wait_lrck_edge(1'b1);
        end
        if (run_errors == 0) begin
            shift_in_word(right);
        end
        frame = {left, right};
    endtask

    task automatic run_stimulus();
        int          pc;
        int          i;
        logic [31:0] op;
        logic [31:0] test;
        logic [31:0] arg;
        logic [31:0] rdat;
        logic [31:0] frame;
        logic [31:0] exp;
        string       name;
        logic        done;
        pc   = 0;
        done = 1'b0;
        while (!done && run_errors == 0) begin
            op   = stim_at(pc);
            test = stim_at(pc + 1);
            arg  = stim_at(pc + 2);
            name = test_name(test);
            case (op)
                OP_END: begin
                    done = 1'b1;
                end
                OP_WRITE: begin
                    bus_cycle(name, 1'b1, arg[1:0], stim_at(pc + 3), rdat);
                    pc = pc + 4;
                end
                OP_READ: begin
                    bus_cycle(name, 1'b0, arg[1:0], 32'h0, rdat);
                    check($sformatf("%s read of address %0d", name, arg), stim_at(pc + 3), rdat);
                    pc = pc + 4;
                end
                OP_CAPTURE: begin
                    for (i = 0; i < int'(arg) && run_errors == 0; i++) begin
                        capture_frame(frame);
                        exp = stim_at(pc + 3 + i);
                        if (run_errors == 0) begin
                            check($sformatf("%s frame %0d left", name, i),
                                  {16'h0, exp[31:16]}, {16'h0, frame[31:16]});
                            check($sformatf("%s frame %0d right", name, i),
                                  {16'h0, exp[15:0]}, {16'h0, frame[15:0]});
                        end
                    end
                    pc = pc + 3 + int'(arg);
                end
                OP_WAIT: begin
                    for (i = 0; i < int'(arg) && run_errors == 0; i++) begin
                        wait_lrck_edge(1'b1);
                    end
                    pc = pc + 3;
                end
                default: begin
                    $display("ERROR: unknown command %0h at stimulus word %0d", op, pc);
                    run_errors++;
                end
            endcase
            if (!done && pc >= 2**STIM_AW) begin
                $display("ERROR: stimulus has no end command");
                run_errors++;
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 2'd0;
        wb_wdat    = 32'h0;
        checks     = 0;
        mismatches = 0;
        run_errors = 0;
        $readmemh("test/aud_stimulus.txt", stim);
        repeat (10) @(posedge bclk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        run_stimulus();
        if (checks == 0) begin
            $display("ERROR: no checks were run");
            run_errors++;
        end
        $display("done: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, run_errors);
        if (mismatches == 0 && run_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/aud_out_top.sv */
`default_nettype none

module aud_out_top import aud_pkg::*; (
    input  wire logic                i_bclk,
    input  wire logic                i_rst_n,
    input  wire logic                i_wb_cyc,
    input  wire logic                i_wb_stb,
    input  wire logic                i_wb_we,
    input  wire logic [WB_ADR_W-1:0] i_wb_adr,
    input  wire logic [WB_DAT_W-1:0] i_wb_dat,
    output logic [WB_DAT_W-1:0]      o_wb_dat,
    output logic                     o_wb_ack,
    input  wire logic                i_daclrck,
    output logic                     o_aud_dacdat
);

    logic               enable;
    logic               mute;
    logic [VOL_W-1:0]   vol_shift;
    logic               push;
    aud_frame_t         push_frame;
    logic               pop;
    aud_frame_t         head_frame;
    logic [LEVEL_W-1:0] level;
    logic               full;
    logic               empty;

    aud_frame_if frame_bus ();

    aud_wb_regs regs_inst (
        .i_bclk           (i_bclk),
        .i_rst_n          (i_rst_n),
        .i_wb_cyc         (i_wb_cyc),
        .i_wb_stb         (i_wb_stb),
        .i_wb_we          (i_wb_we),
        .i_wb_adr         (i_wb_adr),
        .i_wb_dat         (i_wb_dat),
        .o_wb_dat         (o_wb_dat),
        .o_wb_ack         (o_wb_ack),
        .o_enable         (enable),
        .o_mute           (mute),
        .o_vol_shift      (vol_shift),
        .o_push           (push),
        .o_push_frame     (push_frame),
        .i_level          (level),
        .i_full           (full),
        .i_empty          (empty),
        .i_underrun_pulse (frame_bus.underrun)
    );

    aud_frame_fifo fifo_inst (
        .i_bclk       (i_bclk),
        .i_rst_n      (i_rst_n),
        .i_push       (push),
        .i_push_frame (push_frame),
        .i_pop        (pop),
        .o_head_frame (head_frame),
        .o_level      (level),
        .o_full       (full),
        .o_empty      (empty)
    );

    aud_dsp dsp_inst (
        .i_bclk       (i_bclk),
        .i_rst_n      (i_rst_n),
        .i_enable     (enable),
        .i_mute       (mute),
        .i_vol_shift  (vol_shift),
        .o_pop        (pop),
        .i_head_frame (head_frame),
        .i_empty      (empty),
        .frame_if     (frame_bus.src)
    );

    aud_player player_inst (
        .i_bclk       (i_bclk),
        .i_rst_n      (i_rst_n),
        .i_daclrck    (i_daclrck),
        .frame_if     (frame_bus.snk),
        .o_aud_dacdat (o_aud_dacdat)
    );

endmodule

`default_nettype wire

/* rtl/aud_player.sv */
`default_nettype none

module aud_player import aud_pkg::*; (
    input  wire logic i_bclk,
    input  wire logic i_rst_n,
    input  wire logic i_daclrck,
    aud_frame_if.snk  frame_if,
    output logic      o_aud_dacdat
);

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_IDLE,
        ST_LEFT,
        ST_RIGHT
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [CNT_W-1:0] cnt;          // bits sent in this word, minus one
    logic [CNT_W-1:0] cnt_next;
    logic [CNT_W-1:0] bit_idx;
    logic             dat_q;
    logic             dat_next;
    logic             word_end;
    aud_sample_t      cur_sample;

    assign word_end   = (cnt == {CNT_W{1'b1}});   // all 16 bits are out
    assign bit_idx    = CNT_W'(SAMPLE_W - 2) - cnt;
    assign cur_sample = (state == ST_RIGHT) ? frame_if.frame.right : frame_if.frame.left;

    assign frame_if.frame_done = (state == ST_RIGHT) && frame_if.en && word_end && !i_daclrck;
    assign o_aud_dacdat        = dat_q;

    always_comb begin
        state_next = state;
        cnt_next   = cnt;
        dat_next   = dat_q;    // hold between words and when stopped
        case (state)
            ST_WAIT: begin
                if (frame_if.en && i_daclrck) begin
                    state_next = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (!frame_if.en) begin
                    state_next = ST_WAIT;
                end else if (!i_daclrck) begin
                    state_next = ST_LEFT;
                    cnt_next   = '0;
                    dat_next   = frame_if.frame.left[SAMPLE_W-1];
                end
            end
            ST_LEFT: begin
                if (!frame_if.en) begin
                    state_next = ST_WAIT;
                end else if (!word_end) begin
                    cnt_next = cnt + 1'b1;
                    dat_next = cur_sample[bit_idx];
                end else if (i_daclrck) begin
                    state_next = ST_RIGHT;
                    cnt_next   = '0;
                    dat_next   = frame_if.frame.right[SAMPLE_W-1];
                end
            end
            ST_RIGHT: begin
                if (!frame_if.en) begin
                    state_next = ST_WAIT;
                end else if (!word_end) begin
                    cnt_next = cnt + 1'b1;
                    dat_next = cur_sample[bit_idx];
                end else if (!i_daclrck) begin
                    // frame register updates at this edge, so take the msb early
                    state_next = ST_LEFT;
                    cnt_next   = '0;
                    dat_next   = frame_if.next_frame.left[SAMPLE_W-1];
                end
            end
            default: begin
                state_next = ST_WAIT;
            end
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_WAIT;
            cnt   <= '0;
            dat_q <= 1'b0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
            dat_q <= dat_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/aud_dsp.sv */
`default_nettype none

module aud_dsp import aud_pkg::*; (
    input  wire logic             i_bclk,
    input  wire logic             i_rst_n,
    input  wire logic             i_enable,
    input  wire logic             i_mute,
    input  wire logic [VOL_W-1:0] i_vol_shift,
    output logic                  o_pop,
    input  wire aud_frame_t       i_head_frame,
    input  wire logic             i_empty,
    aud_frame_if.src              frame_if
);

    logic       en_q;
    logic       fetch;
    aud_frame_t next_frame;
    aud_frame_t frame_q;

    // arithmetic shift rounds toward negative infinity
    function automatic aud_sample_t scale(input aud_sample_t s,
                                          input logic mute,
                                          input logic [VOL_W-1:0] shift);
        aud_sample_t r;
        r = s >>> shift;
        if (mute) begin
            r = '0;
        end
        return r;
    endfunction

    always_comb begin
        next_frame = '0;    // silence on underrun
        if (!i_empty) begin
            next_frame.left  = scale(i_head_frame.left, i_mute, i_vol_shift);
            next_frame.right = scale(i_head_frame.right, i_mute, i_vol_shift);
        end
    end

    assign fetch = i_enable && (!en_q || frame_if.frame_done);   // first enable or new word
    assign o_pop = fetch && !i_empty;

    assign frame_if.en         = i_enable;
    assign frame_if.frame      = frame_q;
    assign frame_if.next_frame = next_frame;
    assign frame_if.underrun   = fetch && i_empty;

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            en_q    <= 1'b0;
            frame_q <= '0;
        end else begin
            en_q <= i_enable;
            if (fetch) begin
                frame_q <= next_frame;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/aud_wb_regs.sv */
`default_nettype none

module aud_wb_regs import aud_pkg::*; (
    input  wire logic                i_bclk,
    input  wire logic                i_rst_n,
    input  wire logic                i_wb_cyc,
    input  wire logic                i_wb_stb,
    input  wire logic                i_wb_we,
    input  wire logic [WB_ADR_W-1:0] i_wb_adr,
    input  wire logic [WB_DAT_W-1:0] i_wb_dat,
    output logic [WB_DAT_W-1:0]      o_wb_dat,
    output logic                     o_wb_ack,
    output logic                     o_enable,
    output logic                     o_mute,
    output logic [VOL_W-1:0]         o_vol_shift,
    output logic                     o_push,
    output aud_frame_t               o_push_frame,
    input  wire logic [LEVEL_W-1:0]  i_level,
    input  wire logic                i_full,
    input  wire logic                i_empty,
    input  wire logic                i_underrun_pulse
);

    logic                req_new;     // request not yet acked
    logic                wr_en;
    logic                underrun_q;
    logic [WB_DAT_W-1:0] rd_data;

    assign req_new = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr_en   = req_new && i_wb_we;

    always_comb begin
        rd_data = '0;
        case (i_wb_adr)
            ADDR_CTRL: begin
                rd_data[CTRL_EN_BIT]               = o_enable;
                rd_data[CTRL_MUTE_BIT]             = o_mute;
                rd_data[CTRL_VOL_LSB +: VOL_W]     = o_vol_shift;
            end
            ADDR_STATUS: begin
                rd_data[LEVEL_W-1:0]       = i_level;
                rd_data[STAT_FULL_BIT]     = i_full;
                rd_data[STAT_EMPTY_BIT]    = i_empty;
                rd_data[STAT_UNDERRUN_BIT] = underrun_q;
            end
            default: begin
                rd_data = '0;    // sample port reads as zero
            end
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack    <= 1'b0;
            o_wb_dat    <= '0;
            o_enable    <= 1'b0;
            o_mute      <= 1'b0;
            o_vol_shift <= '0;
            o_push      <= 1'b0;
            underrun_q  <= 1'b0;
        end else begin
            o_wb_ack <= req_new;
            o_push   <= wr_en && (i_wb_adr == ADDR_SAMPLE);   // lands in the ack cycle
            if (req_new && !i_wb_we) begin
                o_wb_dat <= rd_data;
            end
            if (wr_en && (i_wb_adr == ADDR_CTRL)) begin
                o_enable    <= i_wb_dat[CTRL_EN_BIT];
                o_mute      <= i_wb_dat[CTRL_MUTE_BIT];
                o_vol_shift <= i_wb_dat[CTRL_VOL_LSB +: VOL_W];
            end
            if (i_underrun_pulse) begin
                underrun_q <= 1'b1;    // a new underrun beats the clear
            end else if (wr_en && (i_wb_adr == ADDR_STATUS) &&
                         i_wb_dat[STAT_UNDERRUN_BIT]) begin
                underrun_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_bclk) begin
        if (wr_en) begin
            o_push_frame <= aud_frame_t'(i_wb_dat);
        end
    end

endmodule

`default_nettype wire

/* rtl/aud_frame_fifo.sv */
`default_nettype none

module aud_frame_fifo import aud_pkg::*; (
    input  wire logic         i_bclk,
    input  wire logic         i_rst_n,
    input  wire logic         i_push,
    input  wire aud_frame_t   i_push_frame,
    input  wire logic         i_pop,
    output aud_frame_t        o_head_frame,
    output logic [LEVEL_W-1:0] o_level,
    output logic              o_full,
    output logic              o_empty
);

    aud_frame_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [LEVEL_W-1:0] level;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign o_full       = (level == LEVEL_W'(FIFO_DEPTH));
    assign o_empty      = (level == '0);
    assign o_level      = level;
    assign do_push      = i_push && !o_full;    // full drops the word
    assign do_pop       = i_pop && !o_empty;
    assign o_head_frame = mem[rd_ptr];          // fall-through head

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge i_bclk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_frame;
        end
    end

endmodule

`default_nettype wire

/* rtl/aud_frame_if.sv */
`default_nettype none

interface aud_frame_if import aud_pkg::*; ();

    logic       en;
    aud_frame_t frame;        // frame being played
    aud_frame_t next_frame;   // what a fetch would load right now
    logic       frame_done;
    logic       underrun;

    modport src (
        output en, frame, next_frame, underrun,
        input  frame_done
    );

    modport snk (
        input  en, frame, next_frame,
        output frame_done
    );

endinterface

`default_nettype wire

/* rtl/aud_pkg.sv */
`default_nettype none

package aud_pkg;

    localparam int SAMPLE_W   = 16;
    localparam int CNT_W      = $clog2(SAMPLE_W);   // player bit counter
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W    = 4;                  // must hold 0..FIFO_DEPTH
    localparam int VOL_W      = 3;

    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 32;

    localparam logic [WB_ADR_W-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS = 2'd1;
    localparam logic [WB_ADR_W-1:0] ADDR_SAMPLE = 2'd2;

    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_MUTE_BIT = 1;
    localparam int CTRL_VOL_LSB  = 2;

    localparam int STAT_FULL_BIT     = 4;   // level sits below
    localparam int STAT_EMPTY_BIT    = 5;
    localparam int STAT_UNDERRUN_BIT = 6;   // write one to clear

    typedef logic signed [SAMPLE_W-1:0] aud_sample_t;

    typedef struct packed {
        aud_sample_t left;    // upper half of the sample word
        aud_sample_t right;
    } aud_frame_t;

endpackage

`default_nettype wire
